// ==== Makefile ====
# Verilator build and run for the UDP echo engine

VERILATOR ?= verilator
TOP       ?= tb_udp_echo
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failures found
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard rtl/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== project.f ====
+incdir+tests
rtl/udp_echo_pkg.sv
rtl/frame_ctrl.sv
rtl/hdr_parser.sv
rtl/payload_fifo.sv
rtl/reply_builder.sv
rtl/udp_echo_top.sv
tests/tb_udp_echo.sv

// ==== rtl/frame_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive and reply control. Frames ending inside the 42-byte header,
// including header-only frames, are dropped without a reply.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module frame_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rx_valid,
  input  logic                   rx_last,
  input  logic                   rx_user,
  input  logic                   hdr_ok,
  input  logic                   fifo_overflow,
  input  logic                   reply_done,
  output udp_echo_pkg::hdr_idx_t hdr_idx,
  output logic                   hdr_capture,
  output logic                   fifo_write,
  output logic                   fifo_commit,
  output logic                   fifo_discard,
  output logic                   reply_start
);

  udp_echo_pkg::ctrl_state_t state;
  udp_echo_pkg::ctrl_state_t state_nxt;
  udp_echo_pkg::hdr_idx_t    hdr_cnt;
  logic                      frame_end;
  logic                      payload_end;
  logic                      accept;
  logic                      rx_open;
  logic                      rx_open_nxt;

  assign frame_end   = rx_valid && rx_last;
  assign payload_end = frame_end && (state == udp_echo_pkg::PAYLOAD);
  assign accept      = payload_end && hdr_ok && !rx_user && !fifo_overflow;

  assign hdr_capture = rx_valid &&
                       (state == udp_echo_pkg::IDLE || state == udp_echo_pkg::HEADER);
  assign hdr_idx     = hdr_cnt;

  // Filtered frames never touch the buffer
  assign fifo_write   = rx_valid && hdr_ok && (state == udp_echo_pkg::PAYLOAD);
  assign fifo_commit  = accept;
  assign fifo_discard = payload_end && !accept;

  // Tracks a frame that started while the reply was still going out
  assign rx_open_nxt = rx_valid ? !rx_last : rx_open;

  always_comb begin
    state_nxt = state;
    case (state)
      udp_echo_pkg::IDLE: begin
        if (rx_valid && !rx_last) begin
          state_nxt = udp_echo_pkg::HEADER;
        end
      end
      udp_echo_pkg::HEADER: begin
        if (frame_end) begin
          state_nxt = udp_echo_pkg::IDLE;
        end else if (rx_valid && hdr_cnt == udp_echo_pkg::HDR_BYTES - 1'b1) begin
          state_nxt = udp_echo_pkg::PAYLOAD;
        end
      end
      udp_echo_pkg::PAYLOAD: begin
        if (frame_end) begin
          state_nxt = accept ? udp_echo_pkg::REPLY : udp_echo_pkg::IDLE;
        end else if (!hdr_ok) begin
          state_nxt = udp_echo_pkg::DISCARD;
        end
      end
      udp_echo_pkg::DISCARD: begin
        if (frame_end) begin
          state_nxt = udp_echo_pkg::IDLE;
        end
      end
      udp_echo_pkg::REPLY: begin
        if (reply_done) begin
          state_nxt = rx_open_nxt ? udp_echo_pkg::DISCARD : udp_echo_pkg::IDLE;
        end
      end
      default: state_nxt = udp_echo_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= udp_echo_pkg::IDLE;
      hdr_cnt     <= '0;
      rx_open     <= 1'b0;
      reply_start <= 1'b0;
    end else begin
      state       <= state_nxt;
      reply_start <= accept;
      rx_open     <= (state == udp_echo_pkg::REPLY) && rx_open_nxt;
      // Counter sits at zero outside the header
      if (state_nxt != udp_echo_pkg::HEADER) begin
        hdr_cnt <= '0;
      end else if (hdr_capture) begin
        hdr_cnt <= hdr_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/hdr_parser.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header store and echo-request match. IP options are not supported, so
// only IHL 5 headers match. The IP checksum is not verified.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hdr_parser #(
  parameter udp_echo_pkg::udp_port_t ECHO_PORT = 16'd1234
) (
  input  logic                   clk,
  input  logic                   rst,
  input  udp_echo_pkg::byte_t    rx_data,
  input  logic                   hdr_capture,
  input  udp_echo_pkg::hdr_idx_t hdr_idx,
  input  udp_echo_pkg::ip_addr_t local_ip,
  input  udp_echo_pkg::hdr_idx_t rd_idx,
  output udp_echo_pkg::byte_t    hdr_byte,
  output logic                   hdr_ok
);

  udp_echo_pkg::byte_t    hdr_mem [udp_echo_pkg::HDR_BYTES];
  logic                   hdr_seen;
  logic [15:0]            eth_type;
  udp_echo_pkg::ip_addr_t ip_dst;
  udp_echo_pkg::udp_port_t udp_dst;

  always_ff @(posedge clk) begin
    if (hdr_capture && hdr_idx < udp_echo_pkg::HDR_BYTES) begin
      hdr_mem[hdr_idx] <= rx_data;
    end
  end

  // Set by the last header byte, cleared when a new frame begins
  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_seen <= 1'b0;
    end else if (hdr_capture) begin
      hdr_seen <= (hdr_idx == udp_echo_pkg::HDR_BYTES - 1'b1);
    end
  end

  assign hdr_byte = hdr_mem[rd_idx];

  // Multi-byte fields are big endian on the wire
  assign eth_type = {hdr_mem[udp_echo_pkg::ETH_TYPE_OFS],
                     hdr_mem[udp_echo_pkg::ETH_TYPE_OFS + 1]};
  assign ip_dst   = {hdr_mem[udp_echo_pkg::IP_DST_OFS],
                     hdr_mem[udp_echo_pkg::IP_DST_OFS + 1],
                     hdr_mem[udp_echo_pkg::IP_DST_OFS + 2],
                     hdr_mem[udp_echo_pkg::IP_DST_OFS + 3]};
  assign udp_dst  = {hdr_mem[udp_echo_pkg::UDP_DST_OFS],
                     hdr_mem[udp_echo_pkg::UDP_DST_OFS + 1]};

  assign hdr_ok = hdr_seen &&
                  (eth_type == udp_echo_pkg::ETHERTYPE_IPV4) &&
                  (hdr_mem[udp_echo_pkg::IP_VER_OFS] == udp_echo_pkg::IP_VER_IHL) &&
                  (hdr_mem[udp_echo_pkg::IP_PROTO_OFS] == udp_echo_pkg::IP_PROTO_UDP) &&
                  (ip_dst == local_ip) &&
                  (udp_dst == ECHO_PORT);

endmodule

// ==== rtl/payload_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Payload buffer holding one frame at a time. Writes stay hidden from the
// reader until commit; a payload longer than the buffer flags overflow.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module payload_fifo #(
  parameter int FIFO_ADDR_WIDTH = 6
) (
  input  logic                clk,
  input  logic                rst,
  input  udp_echo_pkg::byte_t rx_data,
  input  logic                fifo_write,
  input  logic                fifo_commit,
  input  logic                fifo_discard,
  input  logic                fifo_read,
  output udp_echo_pkg::byte_t fifo_data,
  output logic                fifo_empty,
  output logic                fifo_overflow,
  output udp_echo_pkg::byte_t led
);

  localparam int AW    = FIFO_ADDR_WIDTH;
  localparam int DEPTH = 2 ** FIFO_ADDR_WIDTH;

  udp_echo_pkg::byte_t mem [DEPTH];
  logic [AW:0]         wr_spec;
  logic [AW:0]         wr_commit;
  logic [AW:0]         rd_ptr;
  logic [AW:0]         wr_next;
  logic                full;
  logic                write_ok;
  logic                ovf;
  logic                first_now;
  udp_echo_pkg::byte_t first_byte;
  udp_echo_pkg::byte_t first_val;

  // Extra pointer bit tells full from empty
  assign full      = (wr_spec[AW] != rd_ptr[AW]) && (wr_spec[AW-1:0] == rd_ptr[AW-1:0]);
  assign write_ok  = fifo_write && !full;
  assign wr_next   = wr_spec + {{AW{1'b0}}, write_ok};

  // Nothing speculative yet, so this is the frame's first payload byte
  assign first_now = fifo_write && (wr_spec == wr_commit);
  assign first_val = first_now ? rx_data : first_byte;

  assign fifo_empty    = (wr_commit == rd_ptr);
  assign fifo_data     = mem[rd_ptr[AW-1:0]];
  assign fifo_overflow = ovf || (fifo_write && full);

  always_ff @(posedge clk) begin
    if (write_ok) begin
      mem[wr_spec[AW-1:0]] <= rx_data;
    end
    if (first_now) begin
      first_byte <= rx_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_spec   <= '0;
      wr_commit <= '0;
      rd_ptr    <= '0;
      ovf       <= 1'b0;
      led       <= '0;
    end else begin
      if (fifo_commit) begin
        wr_spec   <= wr_next;
        wr_commit <= wr_next;
        led       <= first_val;
        ovf       <= 1'b0;
      end else if (fifo_discard) begin
        wr_spec <= wr_commit;
        ovf     <= 1'b0;
      end else begin
        wr_spec <= wr_next;
        if (fifo_write && full) begin
          ovf <= 1'b1;
        end
      end
      if (fifo_read && !fifo_empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/reply_builder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reply transmitter. One credit is spent per byte sent. The reply expects
// at least one committed payload byte in the buffer.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module reply_builder #(
  parameter udp_echo_pkg::mac_addr_t LOCAL_MAC     = 48'h02_00_00_00_00_01,
  parameter int                      TX_CREDIT_MAX = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   reply_start,
  input  udp_echo_pkg::byte_t    hdr_byte,
  output udp_echo_pkg::hdr_idx_t rd_idx,
  input  udp_echo_pkg::byte_t    fifo_data,
  input  logic                   fifo_empty,
  output logic                   fifo_read,
  input  logic                   tx_credit,
  output udp_echo_pkg::byte_t    tx_data,
  output logic                   tx_valid,
  output logic                   tx_last,
  output logic                   reply_done
);

  localparam int            CW         = $clog2(TX_CREDIT_MAX + 1);
  localparam logic [CW-1:0] CREDIT_MAX = CW'(TX_CREDIT_MAX);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HDR,
    TX_DATA
  } tx_phase_t;

  tx_phase_t              phase;
  udp_echo_pkg::hdr_idx_t hdr_pos;
  logic [CW-1:0]          credit;
  logic                   credit_inc;
  logic                   send;
  udp_echo_pkg::byte_t    hdr_out;
  logic [2:0]             mac_k;
  udp_echo_pkg::byte_t    hold;
  logic                   hold_valid;

  // Output header position to received position
  always_comb begin
    mac_k   = 3'(hdr_pos - udp_echo_pkg::ETH_SRC_OFS);
    rd_idx  = hdr_pos;
    hdr_out = hdr_byte;
    if (hdr_pos < udp_echo_pkg::ETH_SRC_OFS) begin
      rd_idx = hdr_pos - udp_echo_pkg::ETH_DST_OFS + udp_echo_pkg::ETH_SRC_OFS;
    end else if (hdr_pos < udp_echo_pkg::ETH_TYPE_OFS) begin
      hdr_out = LOCAL_MAC[8 * (3'd5 - mac_k) +: 8];
    end else if (hdr_pos >= udp_echo_pkg::IP_SRC_OFS &&
                 hdr_pos < udp_echo_pkg::IP_DST_OFS) begin
      rd_idx = hdr_pos - udp_echo_pkg::IP_SRC_OFS + udp_echo_pkg::IP_DST_OFS;
    end else if (hdr_pos >= udp_echo_pkg::IP_DST_OFS &&
                 hdr_pos < udp_echo_pkg::UDP_SRC_OFS) begin
      rd_idx = hdr_pos - udp_echo_pkg::IP_DST_OFS + udp_echo_pkg::IP_SRC_OFS;
    end else if (hdr_pos >= udp_echo_pkg::UDP_SRC_OFS &&
                 hdr_pos < udp_echo_pkg::UDP_DST_OFS) begin
      rd_idx = hdr_pos - udp_echo_pkg::UDP_SRC_OFS + udp_echo_pkg::UDP_DST_OFS;
    end else if (hdr_pos >= udp_echo_pkg::UDP_DST_OFS &&
                 hdr_pos < udp_echo_pkg::UDP_DST_OFS + 6'd2) begin
      rd_idx = hdr_pos - udp_echo_pkg::UDP_DST_OFS + udp_echo_pkg::UDP_SRC_OFS;
    end else if (hdr_pos >= udp_echo_pkg::UDP_CSUM_OFS) begin
      // UDP checksum left out
      hdr_out = '0;
    end
  end

  assign send = (credit != '0) &&
                ((phase == TX_HDR) || (phase == TX_DATA && hold_valid));

  assign tx_valid   = send;
  assign tx_data    = (phase == TX_DATA) ? hold : hdr_out;
  // Held byte is the last one once the buffer behind it is empty
  assign tx_last    = send && (phase == TX_DATA) && fifo_empty;
  assign reply_done = tx_last;

  // One byte prefetched during the header, refilled as bytes go out
  assign fifo_read = (phase != TX_IDLE) && !fifo_empty &&
                     (!hold_valid || (phase == TX_DATA && send));

  // Pulses past the cap are dropped
  assign credit_inc = tx_credit && ((credit != CREDIT_MAX) || send);

  always_ff @(posedge clk) begin
    if (fifo_read) begin
      hold <= fifo_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= TX_IDLE;
      hdr_pos    <= '0;
      credit     <= '0;
      hold_valid <= 1'b0;
    end else begin
      credit <= credit + CW'(credit_inc) - CW'(send);
      case (phase)
        TX_IDLE: begin
          if (reply_start) begin
            phase <= TX_HDR;
          end
        end
        TX_HDR: begin
          if (send) begin
            if (hdr_pos == udp_echo_pkg::HDR_BYTES - 1'b1) begin
              phase   <= TX_DATA;
              hdr_pos <= '0;
            end else begin
              hdr_pos <= hdr_pos + 1'b1;
            end
          end
        end
        TX_DATA: begin
          if (tx_last) begin
            phase <= TX_IDLE;
          end
        end
        default: phase <= TX_IDLE;
      endcase
      if (fifo_read) begin
        hold_valid <= 1'b1;
      end else if (phase == TX_DATA && send) begin
        hold_valid <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/udp_echo_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, header offsets and protocol constants of the UDP echo engine.
// Offsets assume an untagged Ethernet frame with a 20-byte IPv4 header.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package udp_echo_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [5:0]  hdr_idx_t;

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    PAYLOAD,
    DISCARD,
    REPLY
  } ctrl_state_t;

  // Ethernet + IPv4 + UDP
  localparam hdr_idx_t HDR_BYTES = 6'd42;

  localparam hdr_idx_t ETH_DST_OFS  = 6'd0;
  localparam hdr_idx_t ETH_SRC_OFS  = 6'd6;
  localparam hdr_idx_t ETH_TYPE_OFS = 6'd12;
  localparam hdr_idx_t IP_VER_OFS   = 6'd14;
  localparam hdr_idx_t IP_PROTO_OFS = 6'd23;
  localparam hdr_idx_t IP_SRC_OFS   = 6'd26;
  localparam hdr_idx_t IP_DST_OFS   = 6'd30;
  localparam hdr_idx_t UDP_SRC_OFS  = 6'd34;
  localparam hdr_idx_t UDP_DST_OFS  = 6'd36;
  localparam hdr_idx_t UDP_CSUM_OFS = 6'd40;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam byte_t       IP_VER_IHL     = 8'h45;
  localparam byte_t       IP_PROTO_UDP   = 8'd17;

endpackage

// ==== rtl/udp_echo_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port UDP echo engine on a byte stream. The receive side has no
// back-pressure; frames arriving while a reply is pending are dropped.
// Transmit uses credits, zero after reset.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module udp_echo_top #(
  parameter udp_echo_pkg::mac_addr_t LOCAL_MAC       = 48'h02_00_00_00_00_01,
  parameter udp_echo_pkg::udp_port_t ECHO_PORT       = 16'd1234,
  parameter int                      FIFO_ADDR_WIDTH = 6,
  parameter int                      TX_CREDIT_MAX   = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  udp_echo_pkg::ip_addr_t local_ip,
  input  udp_echo_pkg::byte_t    rx_data,
  input  logic                   rx_valid,
  input  logic                   rx_last,
  input  logic                   rx_user,
  output udp_echo_pkg::byte_t    tx_data,
  output logic                   tx_valid,
  output logic                   tx_last,
  input  logic                   tx_credit,
  output udp_echo_pkg::byte_t    led
);

  udp_echo_pkg::hdr_idx_t hdr_idx;
  udp_echo_pkg::hdr_idx_t rd_idx;
  udp_echo_pkg::byte_t    hdr_byte;
  udp_echo_pkg::byte_t    fifo_data;
  logic                   hdr_capture;
  logic                   hdr_ok;
  logic                   fifo_write;
  logic                   fifo_commit;
  logic                   fifo_discard;
  logic                   fifo_read;
  logic                   fifo_empty;
  logic                   fifo_overflow;
  logic                   reply_start;
  logic                   reply_done;

  frame_ctrl u_frame_ctrl (
    .clk          (clk),
    .rst          (rst),
    .rx_valid     (rx_valid),
    .rx_last      (rx_last),
    .rx_user      (rx_user),
    .hdr_ok       (hdr_ok),
    .fifo_overflow(fifo_overflow),
    .reply_done   (reply_done),
    .hdr_idx      (hdr_idx),
    .hdr_capture  (hdr_capture),
    .fifo_write   (fifo_write),
    .fifo_commit  (fifo_commit),
    .fifo_discard (fifo_discard),
    .reply_start  (reply_start)
  );

  hdr_parser #(
    .ECHO_PORT(ECHO_PORT)
  ) u_hdr_parser (
    .clk        (clk),
    .rst        (rst),
    .rx_data    (rx_data),
    .hdr_capture(hdr_capture),
    .hdr_idx    (hdr_idx),
    .local_ip   (local_ip),
    .rd_idx     (rd_idx),
    .hdr_byte   (hdr_byte),
    .hdr_ok     (hdr_ok)
  );

  payload_fifo #(
    .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
  ) u_payload_fifo (
    .clk          (clk),
    .rst          (rst),
    .rx_data      (rx_data),
    .fifo_write   (fifo_write),
    .fifo_commit  (fifo_commit),
    .fifo_discard (fifo_discard),
    .fifo_read    (fifo_read),
    .fifo_data    (fifo_data),
    .fifo_empty   (fifo_empty),
    .fifo_overflow(fifo_overflow),
    .led          (led)
  );

  reply_builder #(
    .LOCAL_MAC    (LOCAL_MAC),
    .TX_CREDIT_MAX(TX_CREDIT_MAX)
  ) u_reply_builder (
    .clk        (clk),
    .rst        (rst),
    .reply_start(reply_start),
    .hdr_byte   (hdr_byte),
    .rd_idx     (rd_idx),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .fifo_read  (fifo_read),
    .tx_credit  (tx_credit),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_last    (tx_last),
    .reply_done (reply_done)
  );

endmodule

// ==== tests/tb_frame_lib.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame builder, reply model and stream helpers for the echo testbench.
// Included inside tb_udp_echo and uses its signals, queues and counters.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_FRAME_LIB_SVH
`define TB_FRAME_LIB_SVH

// Multi-byte fields go out big endian
function automatic void push_be(input logic [47:0] value, input int nbytes);
  for (int i = nbytes - 1; i >= 0; i--) begin
    frame_q.push_back(value[8*i +: 8]);
  end
endfunction

function automatic void build_frame(input udp_echo_pkg::ip_addr_t dst_ip,
                                    input udp_echo_pkg::udp_port_t dst_port,
                                    input logic [15:0] eth_type,
                                    input int n);
  frame_q.delete();
  push_be(LOCAL_MAC, 6);
  push_be(PEER_MAC, 6);
  push_be(48'(eth_type), 2);
  push_be(48'h45, 1);
  push_be(48'h00, 1);
  push_be(48'(28 + n), 2);
  push_be(48'($random(seed)), 2);
  push_be(48'h4000, 2);
  push_be(48'd64, 1);
  push_be(48'd17, 1);
  // Any IP checksum works since the engine copies it
  push_be(48'($random(seed)), 2);
  push_be(48'(PEER_IP), 4);
  push_be(48'(dst_ip), 4);
  push_be(48'(PEER_PORT), 2);
  push_be(48'(dst_port), 2);
  push_be(48'(8 + n), 2);
  push_be(48'h5a3c, 2);
  for (int i = 0; i < n; i++) begin
    push_be(48'($random(seed)), 1);
  end
endfunction

// Reply: MACs, IPs and ports swapped, UDP checksum zero
function automatic void make_expected();
  exp_q.delete();
  for (int i = 6; i < 12; i++) begin
    exp_q.push_back(frame_q[i]);
  end
  for (int i = 5; i >= 0; i--) begin
    exp_q.push_back(LOCAL_MAC[8*i +: 8]);
  end
  for (int i = 12; i < 26; i++) begin
    exp_q.push_back(frame_q[i]);
  end
  for (int i = 30; i < 34; i++) begin
    exp_q.push_back(frame_q[i]);
  end
  for (int i = 26; i < 30; i++) begin
    exp_q.push_back(frame_q[i]);
  end
  exp_q.push_back(frame_q[36]);
  exp_q.push_back(frame_q[37]);
  exp_q.push_back(frame_q[34]);
  exp_q.push_back(frame_q[35]);
  exp_q.push_back(frame_q[38]);
  exp_q.push_back(frame_q[39]);
  exp_q.push_back(8'h00);
  exp_q.push_back(8'h00);
  for (int i = 42; i < frame_q.size(); i++) begin
    exp_q.push_back(frame_q[i]);
  end
endfunction

task automatic send_frame(input logic bad_end);
  for (int i = 0; i < frame_q.size(); i++) begin
    @(negedge clk);
    rx_valid = 1'b1;
    rx_data  = frame_q[i];
    rx_last  = (i == frame_q.size() - 1);
    rx_user  = bad_end && (i == frame_q.size() - 1);
  end
  @(negedge clk);
  rx_valid = 1'b0;
  rx_last  = 1'b0;
  rx_user  = 1'b0;
endtask

task automatic expect_silence(input int cycles);
  repeat (cycles) @(negedge clk);
  checks++;
  assert (out_q.size() == 0) else begin
    errors++;
    $display("ERROR at %0d ns: %0d unexpected bytes sent", $time, out_q.size());
  end
  out_q.delete();
endtask

task automatic send_dropped(input logic bad_end);
  send_frame(bad_end);
  expect_silence(200);
endtask

task automatic wait_reply(input int limit, output bit ok);
  int start;
  int cycles;
  start  = replies_done;
  cycles = 0;
  while (replies_done == start && cycles < limit) begin
    @(negedge clk);
    cycles++;
  end
  ok = (replies_done != start);
  if (!ok) begin
    errors++;
    $display("Timeout: no reply finished within %0d cycles", limit);
  end
endtask

task automatic check_reply();
  checks++;
  assert (out_q.size() == exp_q.size()) else begin
    errors++;
    $display("ERROR at %0d ns: reply has %0d bytes, expected %0d",
             $time, out_q.size(), exp_q.size());
  end
  for (int i = 0; i < out_q.size() && i < exp_q.size(); i++) begin
    checks++;
    assert (out_q[i] == exp_q[i]) else begin
      errors++;
      $display("ERROR at %0d ns: reply byte %0d is %02h, expected %02h",
               $time, i, out_q[i], exp_q[i]);
    end
  end
  out_q.delete();
endtask

task automatic finish_echo(input int limit);
  bit ok;
  wait_reply(limit, ok);
  if (ok) begin
    check_reply();
  end
  led_exp = exp_q[42];
endtask

task automatic run_echo(input int n, input int limit);
  build_frame(local_ip, ECHO_PORT, 16'h0800, n);
  make_expected();
  send_frame(1'b0);
  finish_echo(limit);
endtask

`endif

// ==== tests/tb_udp_echo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the UDP echo engine. Inputs change on the falling
// edge; the transmit monitor samples on the rising edge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_udp_echo;

  localparam udp_echo_pkg::mac_addr_t LOCAL_MAC       = 48'h02_00_5e_10_00_01;
  localparam udp_echo_pkg::mac_addr_t PEER_MAC        = 48'h02_11_22_33_44_55;
  localparam udp_echo_pkg::ip_addr_t  PEER_IP         = 32'hc0a8_0064;
  localparam udp_echo_pkg::udp_port_t PEER_PORT       = 16'd40000;
  localparam udp_echo_pkg::udp_port_t ECHO_PORT       = 16'd1234;
  localparam int                      FIFO_ADDR_WIDTH = 6;
  localparam int                      TX_CREDIT_MAX   = 16;
  localparam int                      SEED            = 84898;

  logic                   clk = 1'b0;
  logic                   rst;
  udp_echo_pkg::ip_addr_t local_ip;
  udp_echo_pkg::byte_t    rx_data;
  logic                   rx_valid;
  logic                   rx_last;
  logic                   rx_user;
  udp_echo_pkg::byte_t    tx_data;
  logic                   tx_valid;
  logic                   tx_last;
  logic                   tx_credit = 1'b0;
  udp_echo_pkg::byte_t    led;

  udp_echo_pkg::byte_t frame_q[$];
  udp_echo_pkg::byte_t exp_q[$];
  udp_echo_pkg::byte_t out_q[$];
  udp_echo_pkg::byte_t led_exp = 8'h00;
  int seed        = SEED;
  int credit_seed = SEED + 1;
  int checks      = 0;
  int errors      = 0;
  int credit_held = 0;
  int replies_done = 0;
  // 0 no credit, 1 credit every cycle, 2 random bursts
  int credit_mode = 0;
  int burst_left  = 0;
  int gap_left    = 0;

  always #2 clk = ~clk;

  udp_echo_top #(
    .LOCAL_MAC      (LOCAL_MAC),
    .ECHO_PORT      (ECHO_PORT),
    .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH),
    .TX_CREDIT_MAX  (TX_CREDIT_MAX)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .local_ip (local_ip),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_last  (rx_last),
    .rx_user  (rx_user),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_last  (tx_last),
    .tx_credit(tx_credit),
    .led      (led)
  );

  always @(negedge clk) begin
    if (credit_mode == 2) begin
      if (burst_left > 0) begin
        tx_credit = 1'b1;
        burst_left--;
      end else if (gap_left > 0) begin
        tx_credit = 1'b0;
        gap_left--;
      end else begin
        tx_credit  = 1'b0;
        burst_left = 1 + ({$random(credit_seed)} % 20);
        gap_left   = {$random(credit_seed)} % 30;
      end
    end else begin
      tx_credit = (credit_mode == 1);
    end
  end

  // Transmit monitor; a byte may only use credit granted at earlier edges,
  // and pulses beyond the cap add nothing
  always @(posedge clk) begin
    if (!rst) begin
      if (tx_valid) begin
        out_q.push_back(tx_data);
        if (tx_last) begin
          replies_done++;
        end
        checks++;
        assert (credit_held > 0) else begin
          errors++;
          $display("ERROR at %0d ns: byte sent while no credit was held", $time);
        end
        if (credit_held > 0) begin
          credit_held--;
        end
      end
      if (tx_credit && credit_held < TX_CREDIT_MAX) begin
        credit_held++;
      end
    end
  end

  `include "tb_frame_lib.svh"

  task automatic check_led();
    checks++;
    assert (led == led_exp) else begin
      errors++;
      $display("ERROR at %0d ns: led is %02h, expected %02h", $time, led, led_exp);
    end
  endtask

  task automatic test_echo();
    build_frame(local_ip, ECHO_PORT, 16'h0800, 20);
    make_expected();
    send_frame(1'b0);
    // Zero credits after reset, so the reply has to wait
    expect_silence(50);
    credit_mode = 1;
    finish_echo(1000);
    run_echo(1, 1000);
    run_echo(2 ** FIFO_ADDR_WIDTH, 1000);
  endtask

  task automatic test_filtering();
    build_frame(local_ip, ECHO_PORT + 16'd1, 16'h0800, 16);
    send_dropped(1'b0);
    build_frame(local_ip ^ 32'h1, ECHO_PORT, 16'h0800, 16);
    send_dropped(1'b0);
    build_frame(local_ip, ECHO_PORT, 16'h86dd, 16);
    send_dropped(1'b0);
  endtask

  task automatic test_bad_frames();
    build_frame(local_ip, ECHO_PORT, 16'h0800, 16);
    send_dropped(1'b1);
    build_frame(local_ip, ECHO_PORT, 16'h0800, 16);
    while (frame_q.size() > 30) begin
      void'(frame_q.pop_back());
    end
    send_dropped(1'b0);
    build_frame(local_ip, ECHO_PORT, 16'h0800, 2 ** FIFO_ADDR_WIDTH + 16);
    send_dropped(1'b0);
    // Second frame lands while the first reply is stalled
    credit_mode = 0;
    build_frame(local_ip, ECHO_PORT, 16'h0800, 24);
    make_expected();
    send_frame(1'b0);
    build_frame(local_ip, ECHO_PORT, 16'h0800, 24);
    send_frame(1'b0);
    credit_mode = 1;
    finish_echo(1000);
    expect_silence(200);
    run_echo(12, 1000);
  endtask

  task automatic test_credit_flow();
    credit_mode = 2;
    for (int i = 0; i < 3; i++) begin
      run_echo(1 + ({$random(seed)} % 64), 4000);
    end
    credit_mode = 1;
  endtask

  task automatic test_led();
    run_echo(8, 1000);
    check_led();
    build_frame(local_ip, ECHO_PORT + 16'd1, 16'h0800, 8);
    send_dropped(1'b0);
    check_led();
    build_frame(local_ip, ECHO_PORT, 16'h0800, 8);
    send_dropped(1'b1);
    check_led();
  endtask

  initial begin
    rst      = 1'b1;
    local_ip = 32'hc0a8_0102;
    rx_data  = '0;
    rx_valid = 1'b0;
    rx_last  = 1'b0;
    rx_user  = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    checks++;
    assert (!tx_valid && led == 8'h00) else begin
      errors++;
      $display("ERROR at %0d ns: tx_valid or led not zero after reset", $time);
    end
    test_echo();
    test_filtering();
    test_bad_frames();
    test_credit_flow();
    test_led();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
